// File: hdl/bch_enc_cfg.svh
`ifndef BCH_ENC_CFG_SVH
`define BCH_ENC_CFG_SVH

// advances between info accept and the output register input
// must match the parity generator pipeline depth
`define BCH_INFO_DLY 2

// remainder register size, sized for the longest code
`define BCH_MAX_PARITY_BYTES 24

// byte counter width
`define BCH_CNT_W 8

`endif

// File: hdl/bch_types_pkg.sv
`default_nettype none

`include "bch_enc_cfg.svh"

package bch_types_pkg;

	// one stream byte
	typedef logic [7:0] data_byte_t;

	// remainder or generator vector, x^0 at bit 0, short codes left-aligned
	typedef logic [`BCH_MAX_PARITY_BYTES*8-1:0] parity_reg_t;

	typedef logic [`BCH_CNT_W-1:0] byte_cnt_t;

	typedef enum logic [1:0] {
		MODE_P21 = 2'd0,
		MODE_P20 = 2'd1,
		MODE_P16 = 2'd2,
		MODE_P24 = 2'd3
	} code_mode_t;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_INFO  = 2'd1,
		ST_DRAIN = 2'd2,
		ST_CHECK = 2'd3
	} frame_state_t;

endpackage

`default_nettype wire

// File: hdl/bch_code_pkg.sv
`default_nettype none

package bch_code_pkg;

	// generator polynomials without the leading term
	localparam logic [167:0] g_p21 =
		168'h4d_2c8b91f3_7e05a6d4_19c3f28e_b6074a5d_e13f9c27;
	localparam logic [159:0] g_p20 =
		160'h9a3e51c7_42d80fb6_1e7c93a5_d60b28f4_7c1a5e39;
	localparam logic [127:0] g_p16 =
		128'h5f0a3c96_e2b7418d_0c6e9f52_a83b17d5;
	localparam logic [191:0] g_p24 =
		192'hb2e4071c_9d5a63f8_e10c7b29_46d8a3f5_0e7c91b4_3a62d58f;

	function automatic bch_types_pkg::byte_cnt_t check_bytes(
		input bch_types_pkg::code_mode_t mode
	);
		case (mode)
			bch_types_pkg::MODE_P21: return bch_types_pkg::byte_cnt_t'(21);
			bch_types_pkg::MODE_P20: return bch_types_pkg::byte_cnt_t'(20);
			bch_types_pkg::MODE_P16: return bch_types_pkg::byte_cnt_t'(16);
			default:                 return bch_types_pkg::byte_cnt_t'(24);
		endcase
	endfunction

	// left-aligned so the top bit is always the x^(P-1) coefficient
	function automatic bch_types_pkg::parity_reg_t gen_poly(
		input bch_types_pkg::code_mode_t mode
	);
		case (mode)
			bch_types_pkg::MODE_P21: return {g_p21, 24'h0};
			bch_types_pkg::MODE_P20: return {g_p20, 32'h0};
			bch_types_pkg::MODE_P16: return {g_p16, 64'h0};
			default:                 return g_p24;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hdl/bch_frame_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "bch_enc_cfg.svh"

module bch_frame_ctrl (
	input  wire logic                       sys_clk,
	input  wire logic                       rst_n,
	input  wire logic                       in_valid,
	input  wire logic                       in_last,
	input  wire bch_types_pkg::code_mode_t  code_mode,
	input  wire logic                       out_valid,
	input  wire logic                       out_ready,
	output logic                            in_ready,
	output logic                            adv,
	output logic                            info_acc,
	output logic                            info_first,
	output logic                            check_shift,
	output logic                            check_last,
	output bch_types_pkg::code_mode_t       cur_mode
);

	bch_types_pkg::frame_state_t state;
	bch_types_pkg::byte_cnt_t    cnt;
	bch_types_pkg::byte_cnt_t    last_check_cnt;
	logic                        in_phase;
	logic                        drain_done;

	// whole pipeline moves when the output register can be refilled
	assign adv = out_ready | ~out_valid;

	assign in_phase = (state == bch_types_pkg::ST_IDLE) ||
		(state == bch_types_pkg::ST_INFO);

	// ready only offered with a byte present, so idle output stays quiet
	assign in_ready   = in_phase & in_valid & adv;
	assign info_acc   = in_valid & in_ready;
	assign info_first = info_acc & (state == bch_types_pkg::ST_IDLE);

	assign last_check_cnt = bch_code_pkg::check_bytes(cur_mode) - 1'b1;
	assign drain_done     = (cnt == bch_types_pkg::byte_cnt_t'(`BCH_INFO_DLY - 1));

	assign check_shift = (state == bch_types_pkg::ST_CHECK);
	assign check_last  = check_shift && (cnt == last_check_cnt);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state    <= bch_types_pkg::ST_IDLE;
			cnt      <= '0;
			cur_mode <= bch_types_pkg::MODE_P21;
		end else if (adv) begin
			case (state)
				bch_types_pkg::ST_IDLE: begin
					cnt <= '0;
					if (info_acc) begin
						// single-byte frame goes straight to drain
						if (in_last) begin
							state <= bch_types_pkg::ST_DRAIN;
						end else begin
							state <= bch_types_pkg::ST_INFO;
						end
					end
				end
				bch_types_pkg::ST_INFO: begin
					if (info_acc && in_last) begin
						state <= bch_types_pkg::ST_DRAIN;
					end
				end
				bch_types_pkg::ST_DRAIN: begin
					// let the last info byte reach the output side
					if (drain_done) begin
						state <= bch_types_pkg::ST_CHECK;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				bch_types_pkg::ST_CHECK: begin
					if (check_last) begin
						state <= bch_types_pkg::ST_IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= bch_types_pkg::ST_IDLE;
					cnt   <= '0;
				end
			endcase

			// mode held for the whole frame
			if (info_first) begin
				cur_mode <= code_mode;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/bch_parity_gen.sv
`default_nettype none
`timescale 1ns/100ps

`include "bch_enc_cfg.svh"

module bch_parity_gen (
	input  wire logic                       sys_clk,
	input  wire logic                       rst_n,
	input  wire logic                       adv,
	input  wire logic                       info_acc,
	input  wire logic                       info_first,
	input  wire logic                       check_shift,
	input  wire bch_types_pkg::data_byte_t  in_data,
	input  wire bch_types_pkg::code_mode_t  cur_mode,
	output bch_types_pkg::data_byte_t       check_byte
);

	localparam int rem_msb = `BCH_MAX_PARITY_BYTES * 8 - 1;

	// stage one
	bch_types_pkg::data_byte_t   s1_data;
	logic                        s1_vld;
	logic                        s1_first;

	// stage two
	bch_types_pkg::parity_reg_t  rem;
	bch_types_pkg::parity_reg_t  fold;
	bch_types_pkg::parity_reg_t  poly;

	assign poly = bch_code_pkg::gen_poly(cur_mode);

	// eight division steps, msb of the byte first
	always_comb begin : div_byte
		logic fb;
		fold = s1_first ? '0 : rem;
		for (int i = 7; i >= 0; i--) begin
			fb   = s1_data[i] ^ fold[rem_msb];
			fold = (fold << 1) ^ (fb ? poly : '0);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			s1_vld   <= 1'b0;
			s1_first <= 1'b0;
		end else if (adv) begin
			s1_vld   <= info_acc;
			s1_first <= info_first;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (adv) begin
			s1_data <= in_data;
			if (s1_vld) begin
				rem <= fold;
			end else if (check_shift) begin
				// next check byte moves into the top
				rem <= rem << 8;
			end
		end
	end

	assign check_byte = rem[rem_msb -: 8];

endmodule

`default_nettype wire

// File: hdl/bchencoder_mux.sv
`default_nettype none
`timescale 1ns/100ps

`include "bch_enc_cfg.svh"

module bchencoder_mux (
	input  wire logic                       sys_clk,
	input  wire logic                       rst_n,
	input  wire logic                       adv,
	input  wire logic                       info_acc,
	input  wire logic                       check_shift,
	input  wire logic                       check_last,
	input  wire bch_types_pkg::data_byte_t  in_data,
	input  wire bch_types_pkg::data_byte_t  check_byte,
	output logic                            out_valid,
	output logic                            out_last,
	output bch_types_pkg::data_byte_t       out_data
);

	bch_types_pkg::data_byte_t   dly_data [`BCH_INFO_DLY];
	logic [`BCH_INFO_DLY-1:0]    dly_vld;

	// info delay matches the parity pipeline
	always_ff @(posedge sys_clk) begin
		if (adv) begin
			dly_data[0] <= in_data;
			for (int i = 1; i < `BCH_INFO_DLY; i++) begin
				dly_data[i] <= dly_data[i-1];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dly_vld <= '0;
		end else if (adv) begin
			dly_vld <= (dly_vld << 1) | info_acc;
		end
	end

	// info first, then check bytes, else idle
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			out_data  <= '0;
		end else if (adv) begin
			if (dly_vld[`BCH_INFO_DLY-1]) begin
				out_valid <= 1'b1;
				out_last  <= 1'b0;
				out_data  <= dly_data[`BCH_INFO_DLY-1];
			end else if (check_shift) begin
				out_valid <= 1'b1;
				out_last  <= check_last;
				out_data  <= check_byte;
			end else begin
				out_valid <= 1'b0;
				out_last  <= 1'b0;
				out_data  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/bch_encoder_top.sv
`default_nettype none
`timescale 1ns/100ps

module bch_encoder_top (
	input  wire logic                       sys_clk,
	input  wire logic                       rst_n,
	// input stream
	input  wire logic                       in_valid,
	output wire logic                       in_ready,
	input  wire bch_types_pkg::data_byte_t  in_data,
	input  wire logic                       in_last,
	input  wire bch_types_pkg::code_mode_t  code_mode,
	// output stream
	output wire logic                       out_valid,
	input  wire logic                       out_ready,
	output wire bch_types_pkg::data_byte_t  out_data,
	output wire logic                       out_last
);

	wire logic                       adv;
	wire logic                       info_acc;
	wire logic                       info_first;
	wire logic                       check_shift;
	wire logic                       check_last;
	wire bch_types_pkg::code_mode_t  cur_mode;
	wire bch_types_pkg::data_byte_t  check_byte;

	bch_frame_ctrl i_bch_frame_ctrl (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_last     (in_last),
		.code_mode   (code_mode),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.in_ready    (in_ready),
		.adv         (adv),
		.info_acc    (info_acc),
		.info_first  (info_first),
		.check_shift (check_shift),
		.check_last  (check_last),
		.cur_mode    (cur_mode)
	);

	bch_parity_gen i_bch_parity_gen (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.adv         (adv),
		.info_acc    (info_acc),
		.info_first  (info_first),
		.check_shift (check_shift),
		.in_data     (in_data),
		.cur_mode    (cur_mode),
		.check_byte  (check_byte)
	);

	bchencoder_mux i_bchencoder_mux (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.adv         (adv),
		.info_acc    (info_acc),
		.check_shift (check_shift),
		.check_last  (check_last),
		.in_data     (in_data),
		.check_byte  (check_byte),
		.out_valid   (out_valid),
		.out_last    (out_last),
		.out_data    (out_data)
	);

endmodule

`default_nettype wire

// File: verif/bch_encoder_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module bch_encoder_asserts (
	input wire logic        sys_clk,
	input wire logic        rst_n,
	input wire logic        in_valid,
	input wire logic        in_ready,
	input wire logic        in_last,
	input wire logic        out_valid,
	input wire logic        out_ready,
	input wire logic        out_last,
	input wire logic [7:0]  out_data
);

	int   fail_cnt = 0;
	logic busy;
	logic started;

	// set by the last info byte, cleared once the final check byte is loaded
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (in_valid && in_ready && in_last) begin
			busy <= 1'b1;
		end else if (out_valid && out_last) begin
			busy <= 1'b0;
		end
	end

	// first byte offered since reset
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			started <= 1'b0;
		end else if (in_valid) begin
			started <= 1'b1;
		end
	end

	reset_quiet: assert property (@(posedge sys_clk)
		!rst_n |=> (!out_valid && !out_last && !in_ready))
		else begin
			fail_cnt++;
			$error("outputs not quiet after reset");
		end

	idle_quiet: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(!started && !in_valid) |-> (!in_ready && !out_valid && !out_last))
		else begin
			fail_cnt++;
			$error("stream active before any input was offered");
		end

	// frame output has no holes
	frame_contig: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(out_valid && !out_last) |=> out_valid)
		else begin
			fail_cnt++;
			$error("out_valid dropped inside a frame");
		end

	stall_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(out_data) && $stable(out_last)))
		else begin
			fail_cnt++;
			$error("output changed under back-pressure");
		end

	drain_no_ready: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(busy && !(out_valid && out_last)) |-> !in_ready)
		else begin
			fail_cnt++;
			$error("in_ready high before frame finished");
		end

endmodule

bind bch_encoder_top bch_encoder_asserts i_bch_encoder_asserts (
	.sys_clk   (sys_clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.in_last   (in_last),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_last  (out_last),
	.out_data  (out_data)
);

`default_nettype wire

// File: verif/tb_bch_encoder.sv
`default_nettype none
`timescale 1ns/100ps

`include "bch_enc_cfg.svh"

module tb_bch_encoder;

	localparam int n_frames = 14;
	localparam int rem_bits = `BCH_MAX_PARITY_BYTES * 8;

	logic                        sys_clk;
	logic                        rst_n;
	logic                        in_valid;
	logic                        in_last;
	logic                        out_ready;
	bch_types_pkg::data_byte_t   in_data;
	bch_types_pkg::code_mode_t   code_mode;
	wire logic                   in_ready;
	wire logic                   out_valid;
	wire logic                   out_last;
	wire bch_types_pkg::data_byte_t out_data;

	integer                      seed;
	int                          errors;
	int                          checked;
	int                          limit_cycles;
	int                          total_bytes;
	bit                          stall_en;
	bch_types_pkg::data_byte_t   exp_q[$];
	bit                          last_q[$];
	bch_types_pkg::data_byte_t   stim_q[$];
	int                          frame_len[n_frames];
	bch_types_pkg::code_mode_t   frame_mode[n_frames];

	bch_encoder_top i_bch_encoder_top (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.in_last   (in_last),
		.code_mode (code_mode),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_last  (out_last)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// check bytes per code mode
	function automatic int check_count(input bch_types_pkg::code_mode_t mode);
		case (mode)
			bch_types_pkg::MODE_P21: return 21;
			bch_types_pkg::MODE_P20: return 20;
			bch_types_pkg::MODE_P16: return 16;
			default:                 return 24;
		endcase
	endfunction

	// plain long division, one message bit per step
	function automatic bch_types_pkg::parity_reg_t ref_remainder(
		input bch_types_pkg::data_byte_t msg[$],
		input bch_types_pkg::code_mode_t mode
	);
		bch_types_pkg::parity_reg_t r;
		bch_types_pkg::parity_reg_t g;
		logic fb;
		r = '0;
		g = bch_code_pkg::gen_poly(mode);
		foreach (msg[k]) begin
			for (int b = 7; b >= 0; b--) begin
				fb = msg[k][b] ^ r[rem_bits-1];
				r  = r << 1;
				if (fb) begin
					r = r ^ g;
				end
			end
		end
		return r;
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic send_frame(input int len, input bch_types_pkg::code_mode_t mode);
		bch_types_pkg::data_byte_t  msg[$];
		bch_types_pkg::parity_reg_t r;
		int p;
		int i;
		bit acc;
		for (i = 0; i < len; i++) begin
			msg.push_back(stim_q.pop_front());
		end
		r = ref_remainder(msg, mode);
		p = check_count(mode);
		foreach (msg[k]) begin
			exp_q.push_back(msg[k]);
			last_q.push_back(1'b0);
		end
		for (int j = 0; j < p; j++) begin
			exp_q.push_back(r[rem_bits-1-8*j -: 8]);
			last_q.push_back(j == p - 1);
		end
		i = 0;
		while (i < len) begin
			in_valid  = 1'b1;
			in_data   = msg[i];
			in_last   = (i == len - 1);
			code_mode = mode;
			// just before the rising edge
			#9;
			acc = in_ready;
			@(negedge sys_clk);
			if (acc) begin
				i++;
			end
		end
		in_valid = 1'b0;
		in_last  = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(negedge sys_clk);
		end
		repeat (4) @(negedge sys_clk);
	endtask

	always @(negedge sys_clk) begin
		if (stall_en) begin
			out_ready <= (($random(seed) & 3) != 0);
		end else begin
			out_ready <= 1'b1;
		end
	end

	always @(posedge sys_clk) begin : out_monitor
		bch_types_pkg::data_byte_t e;
		bit l;
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("unexpected output byte %02h at %0t with no frame pending",
					out_data, $time);
				errors++;
			end else begin
				e = exp_q.pop_front();
				l = last_q.pop_front();
				checked++;
				assert (out_data == e) else begin
					$display("** Error %0t: out_data expected %02h actual %02h",
						$time, e, out_data);
					errors++;
				end
				assert (out_last == l) else begin
					$display("** Error %0t: out_last expected %0b actual %0b",
						$time, l, out_last);
					errors++;
				end
			end
		end
	end

	initial begin
		#1;
		repeat (limit_cycles) @(posedge sys_clk);
		$display("watchdog expired with %0d bytes still expected", exp_q.size());
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed      = 40124;
		errors    = 0;
		checked   = 0;
		stall_en  = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_last   = 1'b0;
		in_data   = '0;
		code_mode = bch_types_pkg::MODE_P21;
		out_ready = 1'b1;
		total_bytes = 0;
		for (int f = 0; f < n_frames; f++) begin
			if (f < 4) begin
				frame_mode[f] = bch_types_pkg::code_mode_t'(2'(f));
			end else if (f < 8) begin
				frame_mode[f] = bch_types_pkg::code_mode_t'(2'($random(seed)));
			end else begin
				// neighbours always differ
				frame_mode[f] = bch_types_pkg::code_mode_t'(2'(f * 3));
			end
			frame_len[f] = 1 + ($random(seed) & 31);
			for (int b = 0; b < frame_len[f]; b++) begin
				stim_q.push_back(bch_types_pkg::data_byte_t'($random(seed)));
			end
			total_bytes += frame_len[f] + check_count(frame_mode[f]);
		end
		limit_cycles = total_bytes * 40 + 16 + 40;

		repeat (16) @(negedge sys_clk);
		rst_n = 1'b1;

		repeat (20) @(negedge sys_clk);
		$display("test 1 idle after reset: done, errors %0d", errors);

		for (int f = 0; f < 4; f++) begin
			send_frame(frame_len[f], frame_mode[f]);
			wait_drained();
		end
		$display("test 2 one frame per mode: done, errors %0d", errors);

		stall_en = 1'b1;
		for (int f = 4; f < 8; f++) begin
			send_frame(frame_len[f], frame_mode[f]);
		end
		wait_drained();
		stall_en = 1'b0;
		$display("test 3 output stalls: done, errors %0d", errors);

		for (int f = 8; f < n_frames; f++) begin
			send_frame(frame_len[f], frame_mode[f]);
		end
		wait_drained();
		$display("test 4 back-to-back modes: done, errors %0d", errors);

		$display("tests 4, bytes checked %0d, errors %0d, assertion failures %0d",
			checked, errors, i_bch_encoder_top.i_bch_encoder_asserts.fail_cnt);
		if (errors == 0 && i_bch_encoder_top.i_bch_encoder_asserts.fail_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/bch_types_pkg.sv
hdl/bch_code_pkg.sv
hdl/bch_frame_ctrl.sv
hdl/bch_parity_gen.sv
hdl/bchencoder_mux.sv
hdl/bch_encoder_top.sv
verif/bch_encoder_asserts.sv
verif/tb_bch_encoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the BCH encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_bch_encoder \
	--Mdir obj_dir -o tb_sim \
	-f src.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
	exit 0
else
	exit 1
fi
